// ==== design/mem_subsys_settings.svh ====
`ifndef MEM_SUBSYS_SETTINGS_SVH
`define MEM_SUBSYS_SETTINGS_SVH

// Bits per word
`define MEM_WORD_WIDTH 32

// Words per block for 128 bit blocks
`define MEM_BLOCK_WORDS 4

// Blocks in main memory behind a 6 bit block address
`define MEM_N_BLOCKS 64

// Cycles from accepted request to response with a minimum of 2
`define MEM_LATENCY 4

`endif

// ==== design/mem_subsys_pkg.sv ====
`default_nettype none

`include "mem_subsys_settings.svh"

package mem_subsys_pkg;

    // Block index into main memory
    typedef logic [$clog2(`MEM_N_BLOCKS)-1:0] block_addr_t;

    // Byte address of a store with the block bits above the byte offset
    typedef logic [$clog2(`MEM_N_BLOCKS) +
                   $clog2(`MEM_BLOCK_WORDS * `MEM_WORD_WIDTH / 8) - 1:0] addr_t;

    typedef enum logic {
        req_read,
        req_write
    } req_type_t;

    // Store widths for writethrough
    typedef enum logic [1:0] {
        width_byte,
        width_half,
        width_word
    } req_width_t;

    // Owner of the current access
    typedef enum logic {
        icache,
        dcache
    } cache_type_t;

    // One block seen as words or as bytes
    typedef union packed {
        logic [`MEM_BLOCK_WORDS-1:0][`MEM_WORD_WIDTH-1:0] words;
        logic [`MEM_BLOCK_WORDS*`MEM_WORD_WIDTH/8-1:0][7:0] bytes;
    } block_data_u;

endpackage

`default_nettype wire

// ==== design/mem_arbiter_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_fsm (
    input wire clk,
    input wire reset,

    // Icache request that only reads
    input wire icache_req_valid,
    input wire mem_subsys_pkg::block_addr_t icache_req_block_addr,

    // Dcache request
    input wire dcache_req_valid,
    input wire mem_subsys_pkg::req_type_t dcache_req_type,
    input wire mem_subsys_pkg::block_addr_t dcache_req_block_addr,
    input wire mem_subsys_pkg::block_data_u dcache_req_block_data, // Write data
    input wire mem_subsys_pkg::req_width_t dcache_req_width,       // Store width
    input wire mem_subsys_pkg::addr_t dcache_req_addr,             // Store byte address
    input wire dcache_req_writethrough,

    input wire done,                                               // Last access cycle

    output logic icache_req_ready,
    output logic dcache_req_ready,
    output logic icache_resp_valid,
    output logic dcache_resp_valid,

    // Latched request toward timer and memory
    output logic start,
    output mem_subsys_pkg::req_type_t mem_req_type,
    output mem_subsys_pkg::block_addr_t mem_req_block_addr,
    output mem_subsys_pkg::block_data_u mem_req_block_data,
    output mem_subsys_pkg::req_width_t mem_req_width,
    output mem_subsys_pkg::addr_t mem_req_addr,
    output logic mem_req_writethrough
);
    import mem_subsys_pkg::*;

    logic busy;                 // Low in idle, high while an access runs
    cache_type_t last_grant;    // Loser of the last tie wins the next one
    cache_type_t owner;         // Client of the running access
    logic pick_icache;
    logic pick_dcache;
    logic icache_acc;
    logic dcache_acc;

    // Tie break by last grant
    assign pick_icache = icache_req_valid && (!dcache_req_valid || last_grant == dcache);
    assign pick_dcache = dcache_req_valid && (!icache_req_valid || last_grant == icache);

    // Only the tie winner sees ready
    assign icache_req_ready = !busy && !pick_dcache;
    assign dcache_req_ready = !busy && !pick_icache;

    assign icache_acc = icache_req_valid && icache_req_ready;
    assign dcache_acc = dcache_req_valid && dcache_req_ready;

    // Response pulse steered to the owner
    assign icache_resp_valid = done && (owner == icache);
    assign dcache_resp_valid = done && (owner == dcache);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            start <= 1'b0;
            last_grant <= icache;       // First tie goes to dcache
        end else begin
            start <= icache_acc || dcache_acc;  // One cycle after accept
            if (icache_acc || dcache_acc) begin
                busy <= 1'b1;
                last_grant <= icache_acc ? icache : dcache;
            end else if (done) begin
                busy <= 1'b0;                   // Ready again next cycle
            end
        end
    end

    // Granted request held for the whole access
    always_ff @(posedge clk) begin
        if (icache_acc) begin
            owner <= icache;
            mem_req_type <= req_read;           // Icache never writes
            mem_req_block_addr <= icache_req_block_addr;
            mem_req_writethrough <= 1'b0;
        end else if (dcache_acc) begin
            owner <= dcache;
            mem_req_type <= dcache_req_type;
            mem_req_block_addr <= dcache_req_block_addr;
            mem_req_block_data <= dcache_req_block_data;
            mem_req_width <= dcache_req_width;
            mem_req_addr <= dcache_req_addr;
            mem_req_writethrough <= dcache_req_writethrough;
        end
    end

    // One owner per response
    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(icache_resp_valid && dcache_resp_valid))
        else $error("both resp_valid signals high");

    // Timer completion only inside an access
    a_no_idle_done: assert property (@(posedge clk) disable iff (reset)
        done |-> busy)
        else $error("done while idle");

    // Start follows an accept taken in idle
    a_start_from_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> $past(!busy) && busy)
        else $error("start outside an idle accept");

endmodule

`default_nettype wire

// ==== design/mem_latency_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_settings.svh"

module mem_latency_timer (
    input wire clk,
    input wire reset,
    input wire start,   // Accept seen one cycle ago
    output logic done   // Last cycle of the access
);
    localparam int cnt_width = $clog2(`MEM_LATENCY);

    logic [cnt_width-1:0] count;    // Cycles left and zero when idle

    // Start cycle plus MEM_LATENCY-1 counting cycles
    assign done = (count == cnt_width'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_width'(`MEM_LATENCY - 1);
        end else if (count != '0) begin
            count <= count - cnt_width'(1);
        end
    end

    // Arbiter never restarts a running access
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        start |-> count == '0)
        else $error("start while the timer is running");

endmodule

`default_nettype wire

// ==== design/main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_settings.svh"

module main_mem (
    input wire clk,
    input wire done,    // Write commits at the edge ending this cycle
    input wire mem_subsys_pkg::req_type_t mem_req_type,
    input wire mem_subsys_pkg::block_addr_t mem_req_block_addr,
    input wire mem_subsys_pkg::block_data_u mem_req_block_data,
    input wire mem_subsys_pkg::req_width_t mem_req_width,
    input wire mem_subsys_pkg::addr_t mem_req_addr,
    input wire mem_req_writethrough,
    output mem_subsys_pkg::block_data_u resp_block_data
);
    import mem_subsys_pkg::*;

    localparam int off_width = $bits(addr_t) - $bits(block_addr_t);
    localparam int word_bytes = `MEM_WORD_WIDTH / 8;

    block_data_u mem_array [0:`MEM_N_BLOCKS-1];     // One entry per block
    block_data_u stored_block;
    block_data_u merged_block;
    logic [off_width-1:0] byte_off;
    logic [2:0] n_bytes;                            // Bytes in the store
    logic store_req;

    assign stored_block = mem_array[mem_req_block_addr];
    assign byte_off = mem_req_addr[off_width-1:0];
    assign store_req = (mem_req_type == req_write) && mem_req_writethrough;

    always_comb begin
        case (mem_req_width)
            width_byte: n_bytes = 3'd1;
            width_half: n_bytes = 3'd2;
            default:    n_bytes = 3'd4;
        endcase
    end

    // Full block replace, or a partial store merged byte by byte
    always_comb begin
        merged_block = stored_block;
        if (!mem_req_writethrough) begin
            merged_block = mem_req_block_data;
        end else begin
            for (int i = 0; i < word_bytes; i++) begin
                if (i < n_bytes)
                    merged_block.bytes[byte_off + off_width'(i)] =
                        mem_req_block_data.bytes[i];    // Low bytes of word 0
            end
        end
    end

    // Writes return the block as it will be stored
    assign resp_block_data = (mem_req_type == req_write) ? merged_block : stored_block;

    always_ff @(posedge clk) begin
        if (done && mem_req_type == req_write)
            mem_array[mem_req_block_addr] <= merged_block;
    end

    // Alignment of halves
    a_half_align: assert property (@(posedge clk)
        done && store_req && mem_req_width == width_half |-> !byte_off[0])
        else $error("misaligned half store");

    // Alignment of words
    a_word_align: assert property (@(posedge clk)
        done && store_req && mem_req_width == width_word |-> byte_off[1:0] == 2'b00)
        else $error("misaligned word store");

    // Byte address must fall in the addressed block
    a_store_block: assert property (@(posedge clk)
        done && store_req |-> mem_req_addr[$bits(addr_t)-1:off_width] == mem_req_block_addr)
        else $error("store address outside its block");

endmodule

`default_nettype wire

// ==== design/mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input wire clk,
    input wire reset,

    // Icache request and response
    input wire icache_req_valid,
    input wire mem_subsys_pkg::block_addr_t icache_req_block_addr,
    output logic icache_req_ready,
    output logic icache_resp_valid,
    output mem_subsys_pkg::block_data_u icache_resp_block_data,

    // Dcache request and response
    input wire dcache_req_valid,
    input wire mem_subsys_pkg::req_type_t dcache_req_type,
    input wire mem_subsys_pkg::block_addr_t dcache_req_block_addr,
    input wire mem_subsys_pkg::block_data_u dcache_req_block_data,
    input wire mem_subsys_pkg::req_width_t dcache_req_width,
    input wire mem_subsys_pkg::addr_t dcache_req_addr,
    input wire dcache_req_writethrough,
    output logic dcache_req_ready,
    output logic dcache_resp_valid,
    output mem_subsys_pkg::block_data_u dcache_resp_block_data
);
    import mem_subsys_pkg::*;

    logic start;
    logic done;
    req_type_t mem_req_type;
    block_addr_t mem_req_block_addr;
    block_data_u mem_req_block_data;
    req_width_t mem_req_width;
    addr_t mem_req_addr;
    logic mem_req_writethrough;
    block_data_u resp_block_data;

    // Both clients see the same block and resp_valid picks the taker
    assign icache_resp_block_data = resp_block_data;
    assign dcache_resp_block_data = resp_block_data;

    mem_arbiter_fsm _arbiter (
        .clk(clk),
        .reset(reset),
        .icache_req_valid(icache_req_valid),
        .icache_req_block_addr(icache_req_block_addr),
        .dcache_req_valid(dcache_req_valid),
        .dcache_req_type(dcache_req_type),
        .dcache_req_block_addr(dcache_req_block_addr),
        .dcache_req_block_data(dcache_req_block_data),
        .dcache_req_width(dcache_req_width),
        .dcache_req_addr(dcache_req_addr),
        .dcache_req_writethrough(dcache_req_writethrough),
        .done(done),
        .icache_req_ready(icache_req_ready),
        .dcache_req_ready(dcache_req_ready),
        .icache_resp_valid(icache_resp_valid),
        .dcache_resp_valid(dcache_resp_valid),
        .start(start),
        .mem_req_type(mem_req_type),
        .mem_req_block_addr(mem_req_block_addr),
        .mem_req_block_data(mem_req_block_data),
        .mem_req_width(mem_req_width),
        .mem_req_addr(mem_req_addr),
        .mem_req_writethrough(mem_req_writethrough)
    );

    mem_latency_timer _timer (
        .clk(clk),
        .reset(reset),
        .start(start),
        .done(done)
    );

    main_mem _main_mem (
        .clk(clk),
        .done(done),                        // Write commit and response cycle
        .mem_req_type(mem_req_type),
        .mem_req_block_addr(mem_req_block_addr),
        .mem_req_block_data(mem_req_block_data),
        .mem_req_width(mem_req_width),
        .mem_req_addr(mem_req_addr),
        .mem_req_writethrough(mem_req_writethrough),
        .resp_block_data(resp_block_data)
    );

endmodule

`default_nettype wire

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_settings.svh"

module mem_subsys_tb;
    import mem_subsys_pkg::*;

    localparam int n_tests = 18;
    localparam int cycle_limit = n_tests * (`MEM_LATENCY + 4) + 20;

    typedef struct {
        string name;
        cache_type_t client;    // Requester or the dcache side of a pair
        req_type_t rtype;
        block_addr_t baddr;
        logic [3:0] offset;     // Byte offset inside the block
        req_width_t width;
        logic wt;
        int pair;               // 0 alone, 1 tie with icache read, 2 icache read raised while busy
    } test_t;

    logic clk;
    logic reset;
    logic icache_req_valid;
    block_addr_t icache_req_block_addr;
    logic icache_req_ready;
    logic icache_resp_valid;
    block_data_u icache_resp_block_data;
    logic dcache_req_valid;
    req_type_t dcache_req_type;
    block_addr_t dcache_req_block_addr;
    block_data_u dcache_req_block_data;
    req_width_t dcache_req_width;
    addr_t dcache_req_addr;
    logic dcache_req_writethrough;
    logic dcache_req_ready;
    logic dcache_resp_valid;
    block_data_u dcache_resp_block_data;

    test_t tests [n_tests];
    block_data_u ref_mem [`MEM_N_BLOCKS];   // Reference memory
    logic [31:0] rng_state;
    cache_type_t model_last;                // Last granted client
    int cycles = 0;

    mem_subsys dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_fault(input string name, input string msg);
        $display("** Error [%s] %s", name, msg);
        report_fail();
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
            report_fault("timeout", $sformatf("no progress after %0d cycles", cycles));
    end

    task automatic compare_block(input string name, input block_data_u exp,
                                 input block_data_u act);
        if (act !== exp)
            report_fault(name, $sformatf("block expected %h, actual %h", exp, act));
    endtask

    task automatic compare_owner(input string name, input cache_type_t exp,
                                 input cache_type_t act);
        if (act !== exp)
            report_fault(name, $sformatf("owner expected %s, actual %s", exp.name(), act.name()));
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_fault(name, $sformatf("flag expected %b, actual %b", exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_block(output block_data_u blk);
        for (int w = 0; w < `MEM_BLOCK_WORDS; w++) begin
            rng_state = xorshift32(rng_state);
            blk.words[w] = rng_state;
        end
    endtask

    // Block after a full replace or a 1, 2 or 4 byte store from word 0
    function automatic block_data_u model_write(input test_t t, input block_data_u data);
        int nb;
        block_data_u blk;
        nb = (t.width == width_byte) ? 1 : (t.width == width_half) ? 2 : 4;
        blk = t.wt ? ref_mem[t.baddr] : data;
        if (t.wt) begin
            for (int i = 0; i < nb; i++)
                blk.bytes[t.offset + i] = data.bytes[i];
        end
        return blk;
    endfunction

    task automatic load_table();
        tests[0] = '{"tie_reset", dcache, req_write, 6'd20, 4'd0, width_word, 1'b0, 1};
        tests[1] = '{"wr_blk_3", dcache, req_write, 6'd3, 4'd0, width_word, 1'b0, 0};
        tests[2] = '{"wr_blk_17", dcache, req_write, 6'd17, 4'd0, width_word, 1'b0, 0};
        tests[3] = '{"wr_blk_42", dcache, req_write, 6'd42, 4'd0, width_word, 1'b0, 0};
        tests[4] = '{"wr_blk_63", dcache, req_write, 6'd63, 4'd0, width_word, 1'b0, 0};
        tests[5] = '{"rd_blk_3", icache, req_read, 6'd3, 4'd0, width_word, 1'b0, 0};
        tests[6] = '{"rd_blk_17", icache, req_read, 6'd17, 4'd0, width_word, 1'b0, 0};
        tests[7] = '{"rd_blk_42", icache, req_read, 6'd42, 4'd0, width_word, 1'b0, 0};
        tests[8] = '{"rd_blk_63", icache, req_read, 6'd63, 4'd0, width_word, 1'b0, 0};
        tests[9] = '{"st_byte_5", dcache, req_write, 6'd17, 4'd5, width_byte, 1'b1, 0};
        tests[10] = '{"st_half_10", dcache, req_write, 6'd42, 4'd10, width_half, 1'b1, 0};
        tests[11] = '{"st_word_12", dcache, req_write, 6'd3, 4'd12, width_word, 1'b1, 0};
        tests[12] = '{"st_byte_0", dcache, req_write, 6'd63, 4'd0, width_byte, 1'b1, 0};
        tests[13] = '{"rd_st_17", icache, req_read, 6'd17, 4'd0, width_word, 1'b0, 0};
        tests[14] = '{"rd_st_42", dcache, req_read, 6'd42, 4'd0, width_word, 1'b0, 0};
        tests[15] = '{"tie_icache", dcache, req_write, 6'd63, 4'd6, width_half, 1'b1, 1};
        tests[16] = '{"busy_hold", dcache, req_write, 6'd3, 4'd4, width_word, 1'b1, 2};
        tests[17] = '{"rd_st_63", icache, req_read, 6'd63, 4'd0, width_word, 1'b0, 0};
    endtask

    task automatic run_test(input test_t t);
        block_data_u data;
        block_data_u exp_block;
        cache_type_t exp_owner;
        cache_type_t got;
        int acc_cycle;
        int resp_cycle;
        int n_resp;
        logic busy;
        logic i_acc;
        logic d_acc;
        next_block(data);
        n_resp = 0;
        busy = 1'b0;
        resp_cycle = -10;
        if (t.client == dcache) begin
            dcache_req_valid <= 1'b1;
            dcache_req_type <= t.rtype;
            dcache_req_block_addr <= t.baddr;
            dcache_req_block_data <= data;
            dcache_req_width <= t.width;
            dcache_req_addr <= {t.baddr, t.offset};
            dcache_req_writethrough <= t.wt;
        end
        icache_req_valid <= (t.client == icache) || (t.pair == 1);
        icache_req_block_addr <= t.baddr;                   // Pairs read the same block
        while (n_resp < ((t.pair != 0) ? 2 : 1)) begin
            @(posedge clk);                                 // Outputs of the cycle just ended
            if (icache_resp_valid || dcache_resp_valid) begin
                if (!busy || (icache_resp_valid && dcache_resp_valid))
                    report_fault(t.name, "response pulse with no single owner");
                got = icache_resp_valid ? icache : dcache;
                compare_owner(t.name, exp_owner, got);
                if (cycles - acc_cycle != `MEM_LATENCY)
                    report_fault(t.name, $sformatf("latency expected %0d, actual %0d",
                                 `MEM_LATENCY, cycles - acc_cycle));
                compare_block(t.name, exp_block,
                              icache_resp_valid ? icache_resp_block_data : dcache_resp_block_data);
                busy = 1'b0;
                n_resp++;
                resp_cycle = cycles;
            end
            i_acc = icache_req_valid && icache_req_ready;
            d_acc = dcache_req_valid && dcache_req_ready;
            if (i_acc || d_acc) begin
                if (busy || (i_acc && d_acc))
                    report_fault(t.name, "request accepted while another access was running");
                got = i_acc ? icache : dcache;
                if (t.pair == 1 && n_resp == 0)             // Tie goes to the client not granted last
                    compare_owner(t.name, (model_last == icache) ? dcache : icache, got);
                if (t.pair == 2 && got == icache && cycles != resp_cycle + 1)
                    report_fault(t.name, "held request not accepted right after the response");
                model_last = got;
                exp_owner = got;
                acc_cycle = cycles;
                busy = 1'b1;
                if (got == icache) begin
                    exp_block = ref_mem[t.baddr];
                    icache_req_valid <= 1'b0;
                end else begin
                    exp_block = (t.rtype == req_write) ? model_write(t, data) : ref_mem[t.baddr];
                    ref_mem[t.baddr] = exp_block;           // Unchanged on a read
                    dcache_req_valid <= 1'b0;
                    if (t.pair == 2)
                        icache_req_valid <= 1'b1;           // Raised while the dcache access runs
                end
            end
        end
    endtask

    initial begin
        rng_state = 32'd54;
        model_last = icache;                                // First tie goes to dcache
        reset <= 1'b1;
        icache_req_valid <= 1'b0;
        icache_req_block_addr <= '0;
        dcache_req_valid <= 1'b0;
        dcache_req_type <= req_read;
        dcache_req_block_addr <= '0;
        dcache_req_block_data <= '0;
        dcache_req_width <= width_word;
        dcache_req_addr <= '0;
        dcache_req_writethrough <= 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compare_flag("reset_icache_ready", 1'b1, icache_req_ready);
        compare_flag("reset_dcache_ready", 1'b1, dcache_req_ready);
        compare_flag("reset_icache_resp", 1'b0, icache_resp_valid);
        compare_flag("reset_dcache_resp", 1'b0, dcache_resp_valid);
        for (int i = 0; i < n_tests; i++)
            run_test(tests[i]);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
+incdir+design
design/mem_subsys_pkg.sv
design/mem_arbiter_fsm.sv
design/mem_latency_timer.sv
design/main_mem.sv
design/mem_subsys.sv
bench/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/mem_subsys_pkg.sv
      - design/mem_arbiter_fsm.sv
      - design/mem_latency_timer.sv
      - design/main_mem.sv
      - design/mem_subsys.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/mem_subsys_tb.sv
